/* verilog/core_isa_pkg.sv */
// RV64 ISA definitions: instruction word views, opcodes, instruction classes,
// CSR indices and mcause codes.
package core_isa_pkg;

    // ------------------------------
    // Instruction word
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_r_view;

    typedef struct packed {
        logic [11:0] imm12;
        logic [ 4:0] rs1;
        logic [ 2:0] funct3;
        logic [ 4:0] rd;
        logic [ 6:0] opcode;
    } t_i_view;

    typedef union packed {
        t_r_view r;
        t_i_view i;
    } t_instr_word;

    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_JALR     = 7'b1100111,
        OPC_OP_IMM_W = 7'b0011011,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_OP_W     = 7'b0111011,
        OPC_BRANCH   = 7'b1100011,
        OPC_JAL      = 7'b1101111,
        OPC_AUIPC    = 7'b0010111,
        OPC_LUI      = 7'b0110111,
        OPC_FENCE    = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } t_opcode;

    typedef enum logic [3:0] {
        CL_LOAD, CL_OP_IMM, CL_JALR, CL_OP_IMM_W, CL_STORE, CL_OP, CL_OP_W,
        CL_BRANCH, CL_JAL, CL_AUIPC, CL_LUI, CL_FENCE, CL_SYSTEM, CL_ILLEGAL
    } t_instr_class;

    // ------------------------------
    // CSR and trap codes
    // ------------------------------
    typedef logic [2:0] t_csr_idx;

    localparam t_csr_idx CSR_MTVEC  = 3'd3;
    localparam t_csr_idx CSR_MCAUSE = 3'd4;
    localparam t_csr_idx CSR_MEPC   = 3'd5;

    typedef logic [3:0] t_mcause;

    localparam t_mcause MCAUSE_FETCH_MA  = 4'd0;
    localparam t_mcause MCAUSE_ILLEGAL   = 4'd2;
    localparam t_mcause MCAUSE_BREAK     = 4'd3;
    localparam t_mcause MCAUSE_SW_INT    = 4'd3;  // Interrupt flag tells it apart.
    localparam t_mcause MCAUSE_LOAD_MA   = 4'd4;
    localparam t_mcause MCAUSE_STORE_MA  = 4'd6;
    localparam t_mcause MCAUSE_TIMER_INT = 4'd7;
    localparam t_mcause MCAUSE_ECALL     = 4'd11;

endpackage

/* verilog/core_ctrl_pkg.sv */
// Control unit definitions: FSM states, decoded and status structs,
// datapath and trap control bundles with their select codes.
package core_ctrl_pkg;

    typedef enum logic [3:0] {
        FETCH       = 4'd0,
        DECODE      = 4'd1,
        MEMADDR     = 4'd2,
        MEMREAD     = 4'd3,
        MEMWB       = 4'd4,
        MEMWRITE    = 4'd5,
        EXECUTER    = 4'd6,
        ALUWB       = 4'd7,
        EXECUTEI    = 4'd8,
        JAL         = 4'd9,
        BRANCH      = 4'd10,
        LOADI       = 4'd11,
        CALL_0      = 4'd12,
        CSR_EXECUTE = 4'd13,
        CSR_WB      = 4'd14,
        FENCE_I     = 4'd15
    } t_state;

    typedef struct packed {
        core_isa_pkg::t_instr_class instr_class;
        logic                       is_csr_op;  // Funct3 nonzero.
        logic                       is_mret;
        logic                       is_ebreak;
        logic                       m_ext;
        logic                       csr_imm;
        logic                       is_word;    // OP_W or OP_IMM_W.
        core_isa_pkg::t_csr_idx     csr_idx;
    } t_decoded;

    typedef struct packed {
        logic stall_instr;
        logic stall_data;
        logic icache_idle;
        logic instr_ma;
        logic load_ma;
        logic store_ma;
        logic illegal_load;
        logic illegal_alu;
    } t_core_status;

    typedef struct packed {
        logic timer;
        logic software;
    } t_irq;

    // ------------------------------
    // Datapath select codes
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_ADD     = 3'd0,
        ALU_BRANCH  = 3'd1,
        ALU_FUNCT   = 3'd2,
        ALU_FUNCT_W = 3'd3,
        ALU_CSR     = 3'd4
    } t_alu_op;

    typedef enum logic [1:0] {
        SRC1_PC    = 2'd0,
        SRC1_OLDPC = 2'd1,
        SRC1_REG   = 2'd2,
        SRC1_IMM   = 2'd3
    } t_src1;

    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_FOUR = 2'd2,
        SRC2_CSR  = 2'd3
    } t_src2;

    typedef enum logic [2:0] {
        RES_ALUOUT    = 3'd0,
        RES_MEMDATA   = 3'd1,
        RES_ALU       = 3'd2,
        RES_IMM       = 3'd3,
        RES_CSR       = 3'd4,
        RES_CSR_REG   = 3'd5,
        RES_OLD_PC    = 3'd6,
        RES_TRAP_ADDR = 3'd7
    } t_result_src;

    typedef struct packed {
        t_alu_op     alu_op;
        t_src1       src1;
        t_src2       src2;
        t_result_src result_src;
        logic        reg_we;
        logic        pc_update;
        logic        mem_we;
        logic        instr_we;
        logic        start_icache;
        logic        start_dcache;
        logic        branch;
        logic        mem_reg_we;
        logic        fetch_state;
        logic        mem_addr_we;
        logic        invalidate_instr;
    } t_dp_ctrl;

    typedef struct packed {
        core_isa_pkg::t_mcause  mcause;
        logic                   interrupt;
        logic                   mret;
        logic                   csr_we_1;
        logic                   csr_we_2;
        logic                   csr_reg_we;
        core_isa_pkg::t_csr_idx csr_waddr_1;
        core_isa_pkg::t_csr_idx csr_waddr_2;
        core_isa_pkg::t_csr_idx csr_raddr;
    } t_trap_ctrl;

endpackage

/* verilog/instr_decoder.sv */
// Instruction decoder: opcode to class, function flags and CSR index.
`timescale 1ns/10ps

module instr_decoder (
    input  core_isa_pkg::t_instr_word i_instr,
    output core_ctrl_pkg::t_decoded   o_dec
);
    import core_isa_pkg::*;

    t_instr_class instr_class;

    always_comb begin
        case (i_instr.r.opcode)
            OPC_LOAD:     instr_class = CL_LOAD;
            OPC_OP_IMM:   instr_class = CL_OP_IMM;
            OPC_JALR:     instr_class = CL_JALR;
            OPC_OP_IMM_W: instr_class = CL_OP_IMM_W;
            OPC_STORE:    instr_class = CL_STORE;
            OPC_OP:       instr_class = CL_OP;
            OPC_OP_W:     instr_class = CL_OP_W;
            OPC_BRANCH:   instr_class = CL_BRANCH;
            OPC_JAL:      instr_class = CL_JAL;
            OPC_AUIPC:    instr_class = CL_AUIPC;
            OPC_LUI:      instr_class = CL_LUI;
            OPC_FENCE:    instr_class = CL_FENCE;  // Handled as FENCE.I.
            OPC_SYSTEM:   instr_class = CL_SYSTEM;
            default:      instr_class = CL_ILLEGAL;
        endcase
    end

    always_comb begin
        o_dec.instr_class = instr_class;
        o_dec.is_csr_op   = |i_instr.r.funct3;
        o_dec.is_mret     = i_instr.r.funct7[4];
        o_dec.is_ebreak   = i_instr.i.imm12[0];
        o_dec.m_ext       = i_instr.r.funct7[0] &
                            ((instr_class == CL_OP) | (instr_class == CL_OP_W));
        o_dec.csr_imm     = i_instr.r.funct3[2];
        o_dec.is_word     = (instr_class == CL_OP_W) | (instr_class == CL_OP_IMM_W);
        // Compressed CSR index from word bits 26, 22 and 20.
        o_dec.csr_idx     = {i_instr.i.imm12[6], i_instr.i.imm12[2], i_instr.i.imm12[0]};
    end

endmodule

/* verilog/ctrl_sequencer.sv */
// Multicycle control FSM: state register and next-state logic.
`timescale 1ns/10ps

module ctrl_sequencer (
    input  logic                        clk,
    input  logic                        arst,
    input  core_ctrl_pkg::t_decoded     i_dec,
    input  core_ctrl_pkg::t_core_status i_status,
    input  logic                        i_take_trap,
    output core_ctrl_pkg::t_state       o_state
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    t_state state;
    t_state next_state;

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH:    next_state = i_status.stall_instr ? FETCH : DECODE;
            DECODE: begin
                case (i_dec.instr_class)
                    CL_LOAD, CL_STORE, CL_JALR: next_state = MEMADDR;
                    CL_OP_IMM, CL_OP_IMM_W:     next_state = EXECUTEI;
                    CL_OP, CL_OP_W:             next_state = EXECUTER;
                    CL_BRANCH:                  next_state = BRANCH;
                    CL_JAL:                     next_state = JAL;
                    CL_AUIPC:                   next_state = ALUWB;
                    CL_LUI:                     next_state = LOADI;
                    CL_FENCE:                   next_state = FENCE_I;
                    CL_SYSTEM:  next_state = i_dec.is_csr_op ? CSR_EXECUTE : JAL;  // MRET.
                    default:                    next_state = CALL_0;
                endcase
            end
            MEMADDR: begin
                case (i_dec.instr_class)
                    CL_LOAD:  next_state = MEMREAD;
                    CL_STORE: next_state = MEMWRITE;
                    CL_JALR:  next_state = JAL;
                    default:  next_state = FETCH;
                endcase
            end
            MEMREAD:     next_state = i_status.stall_data ? MEMREAD : MEMWB;
            MEMWRITE:    next_state = i_status.stall_data ? MEMWRITE : FETCH;
            EXECUTER:    next_state = ALUWB;
            EXECUTEI:    next_state = ALUWB;
            JAL:         next_state = (i_dec.instr_class == CL_SYSTEM) ? FETCH : ALUWB;
            CSR_EXECUTE: next_state = CSR_WB;
            default:     next_state = FETCH;
        endcase

        // Any recorded trap jumps through CALL_0.
        if (i_take_trap) begin
            next_state = CALL_0;
        end
    end

    assign o_state = state;

    assert property (@(posedge clk) disable iff (arst)
        (state == CALL_0) |=> (state == FETCH));

endmodule

/* verilog/trap_ctrl.sv */
// Trap and interrupt detection, mcause/mepc recording and CSR port controls.
`timescale 1ns/10ps

module trap_ctrl (
    input  core_ctrl_pkg::t_state       i_state,
    input  core_ctrl_pkg::t_decoded     i_dec,
    input  core_ctrl_pkg::t_core_status i_status,
    input  core_ctrl_pkg::t_irq         i_irq,
    output logic                        o_take_trap,
    output core_ctrl_pkg::t_trap_ctrl   o_trap
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic    env_op;
    logic    is_irq;
    t_mcause cause;

    // SYSTEM without funct3 is ECALL, EBREAK or MRET.
    assign env_op = (i_dec.instr_class == CL_SYSTEM) & ~i_dec.is_csr_op;

    // ------------------------------
    // Trap detection
    // ------------------------------
    always_comb begin
        o_take_trap = 1'b0;
        is_irq      = 1'b0;
        cause       = MCAUSE_ILLEGAL;
        case (i_state)
            FETCH: begin
                if (i_status.icache_idle) begin
                    o_take_trap = i_status.instr_ma | i_irq.timer | i_irq.software;
                    is_irq      = i_irq.timer | i_irq.software;
                    if (i_irq.timer) begin
                        cause = MCAUSE_TIMER_INT;  // Timer wins.
                    end else if (i_irq.software) begin
                        cause = MCAUSE_SW_INT;
                    end else begin
                        cause = MCAUSE_FETCH_MA;
                    end
                end
            end
            DECODE: begin
                if (i_dec.instr_class == CL_ILLEGAL) begin
                    o_take_trap = 1'b1;
                end else if (env_op & ~i_dec.is_mret) begin
                    o_take_trap = 1'b1;
                    cause       = i_dec.is_ebreak ? MCAUSE_BREAK : MCAUSE_ECALL;
                end
            end
            MEMREAD: begin
                o_take_trap = i_status.load_ma | i_status.illegal_load;
                cause       = i_status.illegal_load ? MCAUSE_ILLEGAL : MCAUSE_LOAD_MA;
            end
            MEMWRITE: begin
                o_take_trap = i_status.store_ma;
                cause       = MCAUSE_STORE_MA;
            end
            ALUWB:       o_take_trap = i_status.illegal_alu | i_dec.m_ext;
            CSR_EXECUTE: o_take_trap = i_status.illegal_alu;
            default:     o_take_trap = 1'b0;
        endcase
    end

    // ------------------------------
    // CSR controls
    // ------------------------------
    always_comb begin
        o_trap             = '0;
        o_trap.csr_waddr_1 = i_dec.csr_idx;
        o_trap.csr_waddr_2 = i_dec.csr_idx;
        o_trap.csr_raddr   = i_dec.csr_idx;
        case (i_state)
            DECODE:      o_trap.mret      = env_op & i_dec.is_mret;
            JAL:         o_trap.csr_raddr = CSR_MEPC;   // MRET return address.
            CALL_0:      o_trap.csr_raddr = CSR_MTVEC;
            CSR_EXECUTE: begin
                o_trap.csr_we_2   = 1'b1;
                o_trap.csr_reg_we = 1'b1;
            end
            default:     o_trap.mret = 1'b0;
        endcase

        if (o_take_trap) begin
            o_trap.mcause      = cause;
            o_trap.interrupt   = is_irq;
            o_trap.csr_we_1    = 1'b1;
            o_trap.csr_waddr_1 = CSR_MCAUSE;
            o_trap.csr_we_2    = 1'b1;
            o_trap.csr_waddr_2 = CSR_MEPC;  // Old PC.
            o_trap.csr_reg_we  = 1'b0;
        end
    end

endmodule

/* verilog/datapath_ctrl.sv */
// Per-state datapath controls: ALU, operands, result, enables and cache starts.
`timescale 1ns/10ps

module datapath_ctrl (
    input  core_ctrl_pkg::t_state       i_state,
    input  core_ctrl_pkg::t_decoded     i_dec,
    input  core_ctrl_pkg::t_core_status i_status,
    input  logic                        i_take_trap,
    output core_ctrl_pkg::t_dp_ctrl     o_dp
);
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    t_alu_op funct_op;

    assign funct_op = i_dec.is_word ? ALU_FUNCT_W : ALU_FUNCT;

    always_comb begin
        o_dp            = '0;
        o_dp.alu_op     = ALU_ADD;
        o_dp.src1       = SRC1_PC;
        o_dp.src2       = SRC2_REG;
        o_dp.result_src = RES_ALUOUT;

        case (i_state)
            FETCH: begin
                o_dp.src2         = SRC2_FOUR;  // PC + 4.
                o_dp.result_src   = RES_ALU;
                o_dp.start_icache = 1'b1;
                o_dp.fetch_state  = 1'b1;
                o_dp.instr_we     = ~i_status.stall_instr;
                o_dp.pc_update    = ~i_status.stall_instr;
            end
            DECODE: begin
                o_dp.src1 = SRC1_OLDPC;  // Branch and AUIPC target.
                o_dp.src2 = SRC2_IMM;
            end
            MEMADDR: begin
                o_dp.src1        = SRC1_REG;
                o_dp.src2        = SRC2_IMM;
                o_dp.result_src  = RES_ALU;
                o_dp.mem_addr_we = 1'b1;
            end
            MEMREAD: begin
                o_dp.src1         = SRC1_REG;
                o_dp.src2         = SRC2_IMM;
                o_dp.start_dcache = 1'b1;
                o_dp.mem_reg_we   = ~i_status.stall_data;
            end
            MEMWB: begin
                o_dp.result_src = RES_MEMDATA;
                o_dp.reg_we     = 1'b1;
            end
            MEMWRITE: begin
                o_dp.src1         = SRC1_REG;
                o_dp.src2         = SRC2_IMM;
                o_dp.start_dcache = 1'b1;
                o_dp.mem_we       = ~i_status.stall_data;
                o_dp.mem_reg_we   = ~i_status.stall_data;
            end
            EXECUTER: begin
                o_dp.src1   = SRC1_REG;
                o_dp.src2   = SRC2_REG;
                o_dp.alu_op = funct_op;
            end
            EXECUTEI: begin
                o_dp.src1   = SRC1_REG;
                o_dp.src2   = SRC2_IMM;
                o_dp.alu_op = funct_op;
            end
            ALUWB: begin
                o_dp.reg_we = 1'b1;
            end
            JAL: begin
                o_dp.src1       = SRC1_OLDPC;  // Link address.
                o_dp.src2       = SRC2_FOUR;
                o_dp.pc_update  = 1'b1;
                o_dp.result_src = (i_dec.instr_class == CL_SYSTEM) ? RES_CSR : RES_ALUOUT;
            end
            BRANCH: begin
                o_dp.src1   = SRC1_REG;
                o_dp.src2   = SRC2_REG;
                o_dp.alu_op = ALU_BRANCH;
                o_dp.branch = 1'b1;
            end
            LOADI: begin
                o_dp.result_src = RES_IMM;
                o_dp.reg_we     = 1'b1;
            end
            CALL_0: begin
                o_dp.result_src = RES_TRAP_ADDR;  // Jump to mtvec.
                o_dp.pc_update  = 1'b1;
            end
            CSR_EXECUTE: begin
                o_dp.src1       = i_dec.csr_imm ? SRC1_IMM : SRC1_REG;
                o_dp.src2       = SRC2_CSR;
                o_dp.alu_op     = ALU_CSR;
                o_dp.result_src = RES_ALU;
            end
            CSR_WB: begin
                o_dp.result_src = RES_CSR_REG;
                o_dp.reg_we     = 1'b1;
            end
            default: begin
                o_dp.invalidate_instr = 1'b1;  // FENCE_I.
            end
        endcase

        // Old PC goes to mepc and the interrupted step has no side effects.
        if (i_take_trap) begin
            o_dp.result_src   = RES_OLD_PC;
            o_dp.start_icache = 1'b0;
            o_dp.start_dcache = 1'b0;
            o_dp.instr_we     = 1'b0;
            o_dp.pc_update    = 1'b0;
            o_dp.reg_we       = 1'b0;
            o_dp.mem_we       = 1'b0;
            o_dp.mem_reg_we   = 1'b0;
        end
    end

endmodule

/* verilog/main_ctrl.sv */
// Main control unit top: decoder, FSM, trap and datapath control blocks.
`timescale 1ns/10ps

module main_ctrl (
    input  logic                        clk,
    input  logic                        arst,
    input  core_isa_pkg::t_instr_word   i_instr,
    input  core_ctrl_pkg::t_core_status i_status,
    input  core_ctrl_pkg::t_irq         i_irq,
    output core_ctrl_pkg::t_dp_ctrl     o_dp,
    output core_ctrl_pkg::t_trap_ctrl   o_trap
);
    import core_ctrl_pkg::*;

    t_decoded dec;
    t_state   state;
    logic     take_trap;

    instr_decoder u_decoder (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    ctrl_sequencer u_sequencer (
        .clk         (clk),
        .arst        (arst),
        .i_dec       (dec),
        .i_status    (i_status),
        .i_take_trap (take_trap),
        .o_state     (state)
    );

    trap_ctrl u_trap (
        .i_state     (state),
        .i_dec       (dec),
        .i_status    (i_status),
        .i_irq       (i_irq),
        .o_take_trap (take_trap),
        .o_trap      (o_trap)
    );

    datapath_ctrl u_datapath (
        .i_state     (state),
        .i_dec       (dec),
        .i_status    (i_status),
        .i_take_trap (take_trap),
        .o_dp        (o_dp)
    );

endmodule

/* verification/tb_vectors.svh */
// Stimulus and expected-value table for the main control unit testbench.
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [1:0] CHK_NONE  = 2'd0;
localparam logic [1:0] CHK_CSR   = 2'd1;
localparam logic [1:0] CHK_MRET  = 2'd2;
localparam logic [1:0] CHK_FENCE = 2'd3;

typedef struct packed {
    logic [31:0] instr;
    logic [7:0]  status;     // Stall bits here are ignored.
    logic [1:0]  irq;        // {timer, software}.
    logic        rand_si;    // Random stall_instr length.
    logic        rand_sd;    // Random stall_data length.
    logic [3:0]  cycles;     // FETCH to FETCH, no stalls.
    logic        trap;
    logic [3:0]  mcause;
    logic        interrupt;
    logic [1:0]  kind;
} t_vector;

localparam int NUM_VECTORS = 29;

// Columns: instr, status {stall_instr, stall_data, icache_idle, instr_ma, load_ma,
// store_ma, illegal_load, illegal_alu}, irq, si, sd, cycles, trap, mcause, int, kind.
localparam t_vector VECTORS [NUM_VECTORS] = '{
    '{32'h003100B3, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00510093, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h003100BB, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h0051009B, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00813083, 8'h20, 2'b00, 1'b0, 1'b0, 4'd5, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00313423, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00208463, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h010000EF, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h000100E7, 8'h20, 2'b00, 1'b0, 1'b0, 4'd5, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h123450B7, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00001097, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h0000100F, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b0, 4'd0,  1'b0, CHK_FENCE},
    '{32'h305110F3, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_CSR},
    '{32'h3412E0F3, 8'h20, 2'b00, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_CSR},
    '{32'h30200073, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b0, 4'd0,  1'b0, CHK_MRET},
    // Stalled fetch and data accesses.
    '{32'h003100B3, 8'h20, 2'b00, 1'b1, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00813083, 8'h20, 2'b00, 1'b1, 1'b1, 4'd5, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00313423, 8'h20, 2'b00, 1'b1, 1'b1, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    // Exceptions.
    '{32'h0000007F, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b1, 4'd2,  1'b0, CHK_NONE},
    '{32'h00000073, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b1, 4'd11, 1'b0, CHK_NONE},
    '{32'h00100073, 8'h20, 2'b00, 1'b0, 1'b0, 4'd3, 1'b1, 4'd3,  1'b0, CHK_NONE},
    '{32'h00813083, 8'h28, 2'b00, 1'b0, 1'b0, 4'd5, 1'b1, 4'd4,  1'b0, CHK_NONE},
    '{32'h00313423, 8'h24, 2'b00, 1'b0, 1'b0, 4'd5, 1'b1, 4'd6,  1'b0, CHK_NONE},
    '{32'h023100B3, 8'h20, 2'b00, 1'b0, 1'b0, 4'd5, 1'b1, 4'd2,  1'b0, CHK_NONE},
    // Interrupts and misaligned fetch.
    '{32'h00510093, 8'h20, 2'b10, 1'b0, 1'b0, 4'd2, 1'b1, 4'd7,  1'b1, CHK_NONE},
    '{32'h00510093, 8'h20, 2'b01, 1'b0, 1'b0, 4'd2, 1'b1, 4'd3,  1'b1, CHK_NONE},
    '{32'h00510093, 8'h20, 2'b11, 1'b0, 1'b0, 4'd2, 1'b1, 4'd7,  1'b1, CHK_NONE},
    '{32'h00510093, 8'h00, 2'b10, 1'b0, 1'b0, 4'd4, 1'b0, 4'd0,  1'b0, CHK_NONE},
    '{32'h00510093, 8'h30, 2'b00, 1'b0, 1'b0, 4'd2, 1'b1, 4'd0,  1'b0, CHK_NONE}
};

`endif

/* verification/main_ctrl_tb.sv */
// Testbench for the main control unit: table-driven instruction runs with
// cycle count, stall, trap, CSR, MRET and FENCE.I checks.
`timescale 1ns/10ps

module main_ctrl_tb;
    import core_isa_pkg::*;
    import core_ctrl_pkg::*;

    `include "tb_vectors.svh"

    localparam int MAX_WAIT = 64;

    logic         clk;
    logic         arst;
    t_instr_word  instr;
    t_core_status status;
    t_irq         irq;
    t_dp_ctrl     dp;
    t_trap_ctrl   trap;

    integer seed;
    int     errors;
    int     passed;
    logic   timed_out;

    main_ctrl uut (
        .clk      (clk),
        .arst     (arst),
        .i_instr  (instr),
        .i_status (status),
        .i_irq    (irq),
        .o_dp     (dp),
        .o_trap   (trap)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR at %0t: no fetch state within %0d cycles %s", $time, MAX_WAIT, what);
        errors++;
        timed_out = 1'b1;
    endtask

    // Entered 2 ns after a rising edge.
    task automatic wait_fetch();
        int n;
        n = 0;
        while (!dp.fetch_state && n < MAX_WAIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!dp.fetch_state) begin
            report_timeout("after reset");
        end
    endtask

    // ------------------------------
    // One table row, FETCH to FETCH
    // ------------------------------
    task automatic run_row(input int idx);
        t_vector    v;
        int         si_left;
        int         sd_left;
        int         cycles;
        int         exp_cycles;
        int         we1_count;
        int         csr_count;
        int         mret_count;
        int         inval_count;
        int         err_before;
        logic       left_fetch;
        logic       done;
        logic       expect_call;
        logic       saw_call;
        logic       saw_mepc;
        logic [2:0] exp_idx;
        t_src1      exp_src1;
        v           = VECTORS[idx];
        si_left     = v.rand_si ? {$random(seed)} % 6 : 0;
        sd_left     = v.rand_sd ? {$random(seed)} % 6 : 0;
        exp_cycles  = int'(v.cycles) + si_left + sd_left;
        exp_idx     = {v.instr[26], v.instr[22], v.instr[20]};
        exp_src1    = v.instr[14] ? SRC1_IMM : SRC1_REG;  // Immediate CSR forms.
        cycles      = 0;
        we1_count   = 0;
        csr_count   = 0;
        mret_count  = 0;
        inval_count = 0;
        err_before  = errors;
        left_fetch  = 1'b0;
        done        = 1'b0;
        expect_call = 1'b0;
        saw_call    = 1'b0;
        saw_mepc    = 1'b0;
        instr       = t_instr_word'(v.instr);
        while (!done && !timed_out) begin
            status             = t_core_status'(v.status);
            status.stall_instr = (si_left > 0);
            status.stall_data  = (sd_left > 0);
            irq                = left_fetch ? t_irq'(2'b00) : t_irq'(v.irq);
            @(negedge clk);
            cycles++;
            if (expect_call) begin
                if (!dp.pc_update || dp.result_src != RES_TRAP_ADDR) begin
                    report_mismatch($sformatf("row %0d no jump to the trap vector", idx));
                end else begin
                    saw_call = 1'b1;
                end
                expect_call = 1'b0;
            end
            if (dp.fetch_state && status.stall_instr) begin
                if (dp.instr_we || dp.pc_update) begin
                    report_mismatch($sformatf("row %0d fetch enable during stall", idx));
                end
                si_left--;
            end
            if (dp.start_dcache && status.stall_data) begin
                if (dp.mem_we || dp.mem_reg_we) begin
                    report_mismatch($sformatf("row %0d memory enable during stall", idx));
                end
                sd_left--;
            end
            if (trap.csr_we_1) begin
                we1_count++;
                expect_call = 1'b1;
                if (trap.mcause != v.mcause || trap.interrupt != v.interrupt) begin
                    report_mismatch($sformatf("row %0d mcause %0d int %0b, expected %0d int %0b",
                        idx, trap.mcause, trap.interrupt, v.mcause, v.interrupt));
                end
                if (!trap.csr_we_2 || trap.csr_waddr_1 != CSR_MCAUSE ||
                        trap.csr_waddr_2 != CSR_MEPC) begin
                    report_mismatch($sformatf("row %0d trap CSR write ports wrong", idx));
                end
            end
            if (dp.alu_op == ALU_CSR) begin
                csr_count++;
                if (!trap.csr_we_2 || !trap.csr_reg_we || trap.csr_waddr_2 != exp_idx) begin
                    report_mismatch($sformatf("row %0d CSR write index %0d, expected %0d",
                        idx, trap.csr_waddr_2, exp_idx));
                end
                if (dp.src1 != exp_src1 || dp.src2 != SRC2_CSR) begin
                    report_mismatch($sformatf("row %0d CSR operand selects %0d %0d",
                        idx, dp.src1, dp.src2));
                end
            end
            if (trap.mret) begin
                mret_count++;
            end
            if (trap.csr_raddr == CSR_MEPC && dp.pc_update && dp.result_src == RES_CSR) begin
                saw_mepc = 1'b1;
            end
            if (dp.invalidate_instr) begin
                inval_count++;
            end
            @(posedge clk);
            #2;
            if (!dp.fetch_state) begin
                left_fetch = 1'b1;
            end else if (left_fetch) begin
                done = 1'b1;
            end
            if (!done && cycles >= MAX_WAIT) begin
                report_timeout($sformatf("in row %0d", idx));
            end
        end
        if (!timed_out) begin
            if (cycles != exp_cycles) begin
                report_mismatch($sformatf("row %0d took %0d cycles, expected %0d",
                    idx, cycles, exp_cycles));
            end
            if (we1_count != (v.trap ? 1 : 0) || (v.trap && !saw_call)) begin
                report_mismatch($sformatf("row %0d trap recorded %0d times", idx, we1_count));
            end
            if (csr_count != ((v.kind == CHK_CSR) ? 1 : 0)) begin
                report_mismatch($sformatf("row %0d CSR execute seen %0d times", idx, csr_count));
            end
            if (mret_count != ((v.kind == CHK_MRET) ? 1 : 0) ||
                    (v.kind == CHK_MRET && !saw_mepc)) begin
                report_mismatch($sformatf("row %0d mret or mepc read wrong", idx));
            end
            if (inval_count != ((v.kind == CHK_FENCE) ? 1 : 0)) begin
                report_mismatch($sformatf("row %0d invalidate seen %0d times", idx, inval_count));
            end
        end
        if (errors == err_before) begin
            passed++;
        end
        $display("Row %2d instr %h cycles %0d expected %0d %s", idx, v.instr, cycles,
            exp_cycles, (errors == err_before) ? "ok" : "error");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        seed      = 32'h5c01;
        errors    = 0;
        passed    = 0;
        timed_out = 1'b0;
        arst      = 1'b1;
        instr     = t_instr_word'(32'h00000013);
        status    = t_core_status'(8'h80);  // Fetch held off.
        irq       = t_irq'(2'b00);
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (!dp.fetch_state || !dp.start_icache || dp.instr_we || dp.pc_update ||
                dp.reg_we || dp.mem_we || trap.csr_we_1 || trap.csr_we_2) begin
            report_mismatch("control outputs wrong during reset");
        end
        @(posedge clk);
        #2;
        arst = 1'b0;
        wait_fetch();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (!timed_out) begin
                run_row(i);
            end
        end
        $display("%0d of %0d rows passed, %0d errors", passed, NUM_VECTORS, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verification
verilog/core_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/ctrl_sequencer.sv
verilog/trap_ctrl.sv
verilog/datapath_ctrl.sv
verilog/main_ctrl.sv
verification/main_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = main_ctrl_tb
FILELIST  = sim.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
